/* Makefile */
VERILATOR ?= verilator
FLAGS = --binary --timing --assert -j 0
TOP = core_decode_tb
RTL_TOP = core_decode_stage
FILELIST = core_decode_stage.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/core_decode_model.svh */
`ifndef CORE_DECODE_MODEL_SVH
`define CORE_DECODE_MODEL_SVH

// Shifter operand fields, laid out the same way for data processing and load/store.
function automatic core_decode_pkg::snd_decode shifter_operand(input core_decode_pkg::word w);
	core_decode_pkg::snd_decode s;
	s = '0;
	s.is_imm = w[25];
	s.imm = w[7:0];
	s.rot = w[11:8];
	s.r = w[3:0];
	s.shift = core_decode_pkg::shift_op'(w[6:5]);
	s.shift_by_reg = w[4];
	if (w[4])
		s.rs = w[11:8];
	else
		s.shift_imm = w[11:7];
	return s;
endfunction

function automatic core_decode_pkg::insn_decode reference_decode(
	input core_decode_pkg::word w
);
	core_decode_pkg::insn_decode d;
	logic [3:0] op;
	logic mul_pattern;
	logic test_without_s;

	d = '0;
	op = w[24:21];
	mul_pattern = w[27:22] == 6'd0 && w[7:4] == 4'b1001;
	test_without_s = op >= 4'd8 && op <= 4'd11 && !w[20];

	d.cond = core_decode_pkg::cond_code'(w[31:28]);
	d.ctrl.execute = w[31:28] != 4'b1111;
	d.ctrl.conditional = w[31:28] != 4'b1110;

	if (mul_pattern) begin
		d.ctrl.mul = 1'b1;
		d.ctrl.writeback = 1'b1;
		d.ctrl.update_flags = w[20];
		d.mul.accumulate = w[21];
		d.mul.rd = w[19:16];
		d.mul.rn = w[15:12];
		d.mul.rs = w[11:8];
		d.mul.rm = w[3:0];
	end else if (w[27:26] == 2'b00 && !test_without_s) begin
		d.snd = shifter_operand(w);
		d.data.op = core_decode_pkg::alu_op'(op);
		d.data.rn = w[19:16];
		d.data.rd = w[15:12];
		// MOV and MVN take only the second operand.
		d.data.uses_rn = op != 4'd13 && op != 4'd15;
		d.ctrl.writeback = op < 4'd8 || op > 4'd11;
		d.ctrl.update_flags = w[20];
		d.ctrl.undefined = !w[25] && w[7] && w[4];
	end else if (w[27:26] == 2'b01) begin
		d.ctrl.ldst = 1'b1;
		d.ctrl.writeback = w[20];
		// A register offset never carries a register-specified shift.
		d.ctrl.undefined = w[25] && w[4];
		d.snd = shifter_operand(w);
		d.snd.is_imm = !w[25];
		d.data.op = w[23] ? core_decode_pkg::ADD : core_decode_pkg::SUB;
		d.data.rn = w[19:16];
		d.data.rd = w[19:16];
		d.data.uses_rn = 1'b1;
		d.ldst.load = w[20];
		d.ldst.byte_access = w[22];
		d.ldst.pre_index = w[24];
		d.ldst.increment = w[23];
		d.ldst.base_writeback = !w[24] || w[21];
		d.ldst.rn = w[19:16];
		d.ldst.rd = w[15:12];
	end else if (w[27:25] == 3'b101) begin
		d.ctrl.branch = 1'b1;
		d.ctrl.writeback = w[24];
		d.branch.link = w[24];
		d.branch.offset = {{6{w[23]}}, w[23:0]};
	end else begin
		d.ctrl.undefined = 1'b1;
	end
	return d;
endfunction

`endif

/* bench/core_decode_tb.sv */
`timescale 1ns/1ns

module core_decode_tb;

	localparam int NUM_WORDS = 2000;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	// Twenty cycles per word is a generous worst case, and a margin is added on top.
	localparam int TIMEOUT_NS = (RESET_CYCLES + NUM_WORDS * 20 + 200) * CLK_PERIOD;

	logic clk;
	logic reset;
	logic insn_req;
	logic insn_ack;
	core_decode_pkg::word insn;
	logic dec_req;
	logic dec_ack;
	core_decode_pkg::insn_decode dec;

	core_decode_pkg::word words[NUM_WORDS];
	core_decode_pkg::insn_decode expected_q[$];
	core_decode_pkg::word sent_q[$];
	int received = 0;

	logic prev_insn_ack;
	logic prev_dec_req;
	core_decode_pkg::insn_decode prev_dec;

	`include "core_decode_model.svh"

	core_decode_stage dut0 (
		.clk(clk),
		.reset(reset),
		.insn_req(insn_req),
		.insn_ack(insn_ack),
		.insn(insn),
		.dec_req(dec_req),
		.dec_ack(dec_ack),
		.dec(dec)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	// The words lean toward each group's pattern, and one kind in six is fully random.
	function automatic core_decode_pkg::word random_word();
		core_decode_pkg::word w;
		int unsigned kind;
		w = $urandom;
		kind = $urandom_range(0, 5);
		case (kind)
			0: w[27:26] = 2'b00;
			1: w[27:25] = 3'b101;
			2: w[27:26] = 2'b01;
			3: begin
				w[27:22] = 6'b000000;
				w[7:4] = 4'b1001;
			end
			4: begin
				w[27:26] = 2'b00;
				w[24:23] = 2'b10;
				w[20] = 1'b0;
			end
			default: w = w;
		endcase
		return w;
	endfunction

	// Caller is at a falling edge, and so is the return.
	task automatic send_word(input core_decode_pkg::word w);
		insn = w;
		insn_req = 1'b1;
		expected_q.push_back(reference_decode(w));
		sent_q.push_back(w);
		do
			@(negedge clk);
		while (!insn_ack);
		insn_req = 1'b0;
		do
			@(negedge clk);
		while (insn_ack);
	endtask

	// ##############################
	// Source side
	// ##############################

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		insn_req = 1'b0;
		insn = '0;
		dec_ack = 1'b0;
		void'($urandom(1));
		for (int i = 0; i < NUM_WORDS; i++)
			words[i] = random_word();

		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		assert (insn_ack == 1'b0 && dec_req == 1'b0) else
			stop_on_failure($sformatf(
				"FAILED at %0t ns: insn_ack/dec_req after reset, expected 0/0, got %b/%b",
				$time, insn_ack, dec_req));
		assert (dec == '0) else
			stop_on_failure($sformatf(
				"FAILED at %0t ns: dec after reset, expected 0, got %h",
				$time, dec));

		for (int i = 0; i < NUM_WORDS; i++)
			send_word(words[i]);

		while (received < NUM_WORDS)
			@(negedge clk);
		repeat (10) @(negedge clk);
		assert (!insn_ack && !dec_req) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			stop_on_failure($sformatf(
				"FAILED at %0t ns: insn_ack/dec_req after last word, expected 0/0, got %b/%b",
				$time, insn_ack, dec_req));
		end
	end

	// ##############################
	// Sink side
	// ##############################

	initial begin
		int unsigned delay;
		core_decode_pkg::insn_decode expected;
		core_decode_pkg::word w;
		forever begin
			@(negedge clk);
			if (!reset && dec_req && !dec_ack) begin
				assert (expected_q.size() > 0) else
					stop_on_failure("dec_req was raised with no word outstanding");
				expected = expected_q.pop_front();
				w = sent_q.pop_front();
				assert (dec == expected) else
					stop_on_failure($sformatf(
						"FAILED at %0t ns: dec for insn %h, expected %h, got %h",
						$time, w, expected, dec));
				received++;
				delay = $urandom_range(0, 5);
				repeat (delay) @(negedge clk);
				dec_ack = 1'b1;
				do
					@(negedge clk);
				while (dec_req);
				dec_ack = 1'b0;
			end
		end
	end

	// The handshake rules are sampled away from the rising edge.
	always @(negedge clk) begin
		if (!reset) begin
			assert (!(insn_ack && !prev_insn_ack && prev_dec_req)) else
				stop_on_failure("insn_ack rose while the previous record was still pending");
			assert (!(dec_req && prev_dec_req) || dec == prev_dec) else
				stop_on_failure($sformatf(
					"FAILED at %0t ns: dec changed under dec_req, was %h, now %h",
					$time, prev_dec, dec));
		end
		prev_insn_ack = insn_ack;
		prev_dec_req = dec_req;
		prev_dec = dec;
	end

	initial begin
		#(TIMEOUT_NS);
		stop_on_failure("Timeout: the words were not all decoded within the time limit");
	end

endmodule

/* core_decode_stage.f */
+incdir+bench
source/core_decode_pkg.sv
source/snd_port.sv
source/core_decode_class.sv
source/core_decode_snd.sv
source/core_decode_data.sv
source/core_decode_ldst.sv
source/core_decode_mul.sv
source/core_decode.sv
source/core_decode_stage.sv
bench/core_decode_tb.sv

/* source/core_decode.sv */
`timescale 1ns/1ns

module core_decode (
	input core_decode_pkg::word insn,
	output core_decode_pkg::insn_decode dec
);

	core_decode_pkg::insn_group group;
	logic execute, conditional;
	core_decode_pkg::branch_decode dec_branch;

	core_decode_pkg::data_decode data;
	logic data_writeback, data_update_flags, data_undefined;

	core_decode_pkg::ldst_decode ldst;
	core_decode_pkg::data_decode ldst_alu;
	logic ldst_writeback, ldst_undefined;

	core_decode_pkg::mul_decode mul;
	logic mul_update_flags;

	snd_port snd_if();

	core_decode_class classify (
		.insn(insn),
		.group(group),
		.execute(execute),
		.conditional(conditional),
		.dec_branch(dec_branch)
	);

	core_decode_snd snd_operand (
		.insn(insn),
		.snd(snd_if)
	);

	core_decode_data group_data (
		.insn(insn),
		.snd(snd_if),
		.decode(data),
		.writeback(data_writeback),
		.update_flags(data_update_flags),
		.undefined(data_undefined)
	);

	core_decode_ldst group_ldst (
		.insn(insn),
		.snd(snd_if),
		.decode(ldst),
		.alu(ldst_alu),
		.writeback(ldst_writeback),
		.undefined(ldst_undefined)
	);

	core_decode_mul group_mul (
		.insn(insn),
		.decode(mul),
		.update_flags(mul_update_flags)
	);

	// ##############################
	// Group merge
	// ##############################

	always_comb begin
		dec = '0;
		dec.cond = core_decode_pkg::cond_code'(insn[31:28]);
		dec.ctrl.execute = execute;
		dec.ctrl.conditional = conditional;

		case (group)
			core_decode_pkg::GROUP_DATA: begin
				dec.ctrl.undefined = data_undefined;
				dec.ctrl.writeback = data_writeback;
				dec.ctrl.update_flags = data_update_flags;
				dec.snd = snd_if.decode;
				dec.data = data;
			end
			core_decode_pkg::GROUP_BRANCH: begin
				dec.ctrl.branch = 1'b1;
				dec.ctrl.writeback = dec_branch.link;
				dec.branch = dec_branch;
			end
			core_decode_pkg::GROUP_LDST: begin
				dec.ctrl.ldst = 1'b1;
				dec.ctrl.undefined = ldst_undefined;
				dec.ctrl.writeback = ldst_writeback;
				dec.snd = snd_if.decode;
				// Load/store reads bit 25 the other way round.
				dec.snd.is_imm = !snd_if.is_imm_rule;
				dec.data = ldst_alu;
				dec.ldst = ldst;
			end
			core_decode_pkg::GROUP_MUL: begin
				dec.ctrl.mul = 1'b1;
				dec.ctrl.writeback = 1'b1;
				dec.ctrl.update_flags = mul_update_flags;
				dec.mul = mul;
			end
			default:
				dec.ctrl.undefined = 1'b1;
		endcase
	end

endmodule

/* source/core_decode_class.sv */
`timescale 1ns/1ns

module core_decode_class (
	input core_decode_pkg::word insn,
	output core_decode_pkg::insn_group group,
	output logic execute,
	output logic conditional,
	output core_decode_pkg::branch_decode dec_branch
);

	core_decode_pkg::cond_code cond;
	logic is_mul;
	logic is_data;
	logic is_test_no_s;
	logic is_ldst;
	logic is_branch;

	assign cond = core_decode_pkg::cond_code'(insn[31:28]);
	assign execute = cond != core_decode_pkg::NV;
	assign conditional = cond != core_decode_pkg::AL;

	assign is_mul = insn[27:22] == 6'b000000 && insn[7:4] == 4'b1001;
	assign is_data = insn[27:26] == 2'b00;
	assign is_ldst = insn[27:26] == 2'b01;
	assign is_branch = insn[27:25] == 3'b101;

	// TST..CMN without S is where the PSR transfers and swaps live.
	assign is_test_no_s = insn[24:23] == 2'b10 && !insn[20];

	always_comb begin
		if (is_mul)
			group = core_decode_pkg::GROUP_MUL;
		else if (is_data && !is_test_no_s)
			group = core_decode_pkg::GROUP_DATA;
		else if (is_ldst)
			group = core_decode_pkg::GROUP_LDST;
		else if (is_branch)
			group = core_decode_pkg::GROUP_BRANCH;
		else
			group = core_decode_pkg::GROUP_UNDEF;
	end

	// Word offset, the 24-bit field sign-extended to 30 bits.
	assign dec_branch.link = insn[24];
	assign dec_branch.offset = {{6{insn[23]}}, insn[23:0]};

endmodule

/* source/core_decode_data.sv */
`timescale 1ns/1ns

module core_decode_data (
	input core_decode_pkg::word insn,
	snd_port.user snd,
	output core_decode_pkg::data_decode decode,
	output logic writeback,
	output logic update_flags,
	output logic undefined
);

	core_decode_pkg::alu_op op;

	assign op = core_decode_pkg::alu_op'(insn[24:21]);

	assign decode.op = op;
	assign decode.rn = insn[19:16];
	assign decode.rd = insn[15:12];

	always_comb begin
		case (op)
			core_decode_pkg::MOV,
			core_decode_pkg::MVN:
				decode.uses_rn = 1'b0;
			default:
				decode.uses_rn = 1'b1;
		endcase
	end

	// Compare and test opcodes only set flags.
	always_comb begin
		case (op)
			core_decode_pkg::TST,
			core_decode_pkg::TEQ,
			core_decode_pkg::CMP,
			core_decode_pkg::CMN:
				writeback = 1'b0;
			default:
				writeback = 1'b1;
		endcase
	end

	assign update_flags = insn[20];

	// Bit 25 set means a rotated immediate for this group.
	assign undefined = !snd.is_imm_rule && snd.undefined;

endmodule

/* source/core_decode_ldst.sv */
`timescale 1ns/1ns

module core_decode_ldst (
	input core_decode_pkg::word insn,
	snd_port.user snd,
	output core_decode_pkg::ldst_decode decode,
	output core_decode_pkg::data_decode alu,
	output logic writeback,
	output logic undefined
);

	logic increment;
	core_decode_pkg::reg_num rn;

	assign increment = insn[23];
	assign rn = insn[19:16];

	assign decode.load = insn[20];
	assign decode.byte_access = insn[22];
	assign decode.pre_index = insn[24];
	assign decode.increment = increment;
	assign decode.rn = rn;
	assign decode.rd = insn[15:12];

	// Post-indexed accesses always update the base.
	assign decode.base_writeback = !insn[24] || insn[21];

	assign writeback = insn[20];

	// ##############################
	// Address calculation
	// ##############################

	// The ALU forms rn +/- offset, the result goes back to rn.
	always_comb begin
		alu.op = increment ? core_decode_pkg::ADD : core_decode_pkg::SUB;
		alu.rn = rn;
		alu.rd = rn;
		alu.uses_rn = 1'b1;
	end

	// Here bit 25 set selects the register offset, which takes no
	// register-specified shift. Bit 4 set lands in the media space.
	assign undefined = snd.is_imm_rule && snd.shift_by_reg_rule;

endmodule

/* source/core_decode_mul.sv */
`timescale 1ns/1ns

module core_decode_mul (
	input core_decode_pkg::word insn,
	output core_decode_pkg::mul_decode decode,
	output logic update_flags
);

	// MLA computes rd = rm * rs + rn.
	assign decode.accumulate = insn[21];
	assign decode.rd = insn[19:16];
	assign decode.rn = insn[15:12];
	assign decode.rs = insn[11:8];
	assign decode.rm = insn[3:0];

	assign update_flags = insn[20];

endmodule

/* source/core_decode_pkg.sv */
package core_decode_pkg;

	// ##############################
	// Basic types
	// ##############################

	typedef logic [31:0] word;
	typedef logic [3:0] reg_num;

	typedef enum logic [3:0] {
		EQ,
		NE,
		CS,
		CC,
		MI,
		PL,
		VS,
		VC,
		HI,
		LS,
		GE,
		LT,
		GT,
		LE,
		AL,
		NV
	} cond_code;

	// Opcode order follows bits 24:21 of a data-processing word.
	typedef enum logic [3:0] {
		AND,
		EOR,
		SUB,
		RSB,
		ADD,
		ADC,
		SBC,
		RSC,
		TST,
		TEQ,
		CMP,
		CMN,
		ORR,
		MOV,
		BIC,
		MVN
	} alu_op;

	typedef enum logic [1:0] {
		LSL,
		LSR,
		ASR,
		ROR
	} shift_op;

	typedef enum logic [2:0] {
		GROUP_DATA,
		GROUP_BRANCH,
		GROUP_LDST,
		GROUP_MUL,
		GROUP_UNDEF
	} insn_group;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_REQ_LOW,
		WAIT_OUT_ACK
	} stage_state;

	// ##############################
	// Decoded records
	// ##############################

	// For load/store the 12-bit immediate offset is {rot, imm}.
	typedef struct packed {
		logic is_imm;
		logic [7:0] imm;
		logic [3:0] rot;
		reg_num r;
		shift_op shift;
		logic [4:0] shift_imm;
		reg_num rs;
		logic shift_by_reg;
	} snd_decode;

	typedef struct packed {
		logic execute;
		logic undefined;
		logic conditional;
		logic writeback;
		logic update_flags;
		logic branch;
		logic ldst;
		logic mul;
	} ctrl_decode;

	typedef struct packed {
		alu_op op;
		reg_num rn;
		reg_num rd;
		logic uses_rn;
	} data_decode;

	typedef struct packed {
		logic link;
		logic [29:0] offset;
	} branch_decode;

	typedef struct packed {
		logic load;
		logic byte_access;
		logic pre_index;
		logic increment;
		logic base_writeback;
		reg_num rn;
		reg_num rd;
	} ldst_decode;

	typedef struct packed {
		logic accumulate;
		reg_num rd;
		reg_num rn;
		reg_num rs;
		reg_num rm;
	} mul_decode;

	typedef struct packed {
		cond_code cond;
		ctrl_decode ctrl;
		snd_decode snd;
		data_decode data;
		branch_decode branch;
		ldst_decode ldst;
		mul_decode mul;
	} insn_decode;

endpackage

/* source/core_decode_snd.sv */
`timescale 1ns/1ns

module core_decode_snd (
	input core_decode_pkg::word insn,
	snd_port.source snd
);

	logic by_reg;

	assign by_reg = insn[4];

	assign snd.is_imm_rule = insn[25];
	assign snd.shift_by_reg_rule = by_reg;

	// ##############################
	// Immediate form
	// ##############################

	assign snd.decode.is_imm = insn[25];
	assign snd.decode.imm = insn[7:0];
	assign snd.decode.rot = insn[11:8];

	// ##############################
	// Register form
	// ##############################

	assign snd.decode.r = insn[3:0];
	assign snd.decode.shift = core_decode_pkg::shift_op'(insn[6:5]);
	assign snd.decode.shift_by_reg = by_reg;

	// Only one of the two shift amount sources is meaningful.
	assign snd.decode.shift_imm = by_reg ? 5'd0 : insn[11:7];
	assign snd.decode.rs = by_reg ? insn[11:8] : 4'd0;

	// Bit 7 with bit 4 is the multiply and extra load/store space,
	// not a shifter operand.
	assign snd.undefined = insn[7] && by_reg;

endmodule

/* source/core_decode_stage.sv */
`timescale 1ns/1ns

module core_decode_stage (
	input logic clk,
	input logic reset,

	input logic insn_req,
	output logic insn_ack,
	input core_decode_pkg::word insn,

	output logic dec_req,
	input logic dec_ack,
	output core_decode_pkg::insn_decode dec
);

	core_decode_pkg::stage_state state;
	core_decode_pkg::insn_decode decoded;

	core_decode decoder (
		.insn(insn),
		.dec(decoded)
	);

	// ##############################
	// Handshake sequencer
	// ##############################

	// The two handshakes release on their own. The FSM only tracks
	// when both have finished, so a slow sink stalls the next capture.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= core_decode_pkg::IDLE;
			insn_ack <= 1'b0;
			dec_req <= 1'b0;
			dec <= '0;
		end else begin
			if (insn_ack && !insn_req)
				insn_ack <= 1'b0;

			if (dec_req && dec_ack)
				dec_req <= 1'b0;

			case (state)
				core_decode_pkg::IDLE:
					if (insn_req) begin
						dec <= decoded;
						insn_ack <= 1'b1;
						dec_req <= 1'b1;
						state <= core_decode_pkg::WAIT_REQ_LOW;
					end
				core_decode_pkg::WAIT_REQ_LOW:
					if (!insn_req)
						state <= core_decode_pkg::WAIT_OUT_ACK;
				core_decode_pkg::WAIT_OUT_ACK:
					if (!dec_req && !dec_ack)
						state <= core_decode_pkg::IDLE;
				default:
					state <= core_decode_pkg::IDLE;
			endcase
		end
	end

endmodule

/* source/snd_port.sv */
`timescale 1ns/1ns

// Shifter operand as seen at word level. is_imm_rule is bit 25 and
// shift_by_reg_rule is bit 4, the users pick the polarity they need.
interface snd_port;
	core_decode_pkg::snd_decode decode;
	logic is_imm_rule;
	logic shift_by_reg_rule;
	logic undefined;

	modport source(
		output decode,
		output is_imm_rule,
		output shift_by_reg_rule,
		output undefined
	);

	modport user(
		input decode,
		input is_imm_rule,
		input shift_by_reg_rule,
		input undefined
	);
endinterface
